//--- rtl/tx_pkg.sv
package tx_pkg;

    // Parallel word from the source
    typedef logic [15:0] word_t;

    // One quarter-rate group of four bits
    typedef logic [3:0] nibble_t;

    // Bit position within a word
    typedef logic [3:0] cnt_t;

    // Quarter phases in send order
    typedef enum logic [1:0] {
        ph_q  = 2'd0,  // Nibble bit 0, load point
        ph_i  = 2'd1,  // Nibble bit 1
        ph_qb = 2'd2,  // Nibble bit 2
        ph_ib = 2'd3   // Nibble bit 3
    } qphase_e;

    // Delay code width used unless the top level overrides it
    localparam int DELAY_W_DEF = 4;

endpackage

//--- rtl/input_divider.sv
`timescale 1ns/1ns
`default_nettype none

module input_divider (
    input  wire logic mdll_clk,   // Bit-rate clock
    input  wire logic rst_n,
    input  wire logic en,         // Divider enable
    output logic      word_load,  // One pulse per 16 bits
    output logic      nib_load,   // One pulse per 4 bits
    output logic      run         // Datapath active level
);

    import tx_pkg::*;

    cnt_t cnt;  // Bit position within the word

    // Counts bits while enabled
    always_ff @(posedge mdll_clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (!en) begin
            cnt <= '0;  // Parked so restart lines up again
        end else begin
            cnt <= cnt + cnt_t'(1);  // Wraps every 16 bits
        end
    end

    // Last bit slot of the word
    assign word_load = en && (cnt == cnt_t'(15));

    // Last bit slot of each nibble
    // Coincides with word_load once per word
    assign nib_load = en && (cnt[1:0] == 2'b11);

    // Output gate for the delay line
    // Registered copy of en, drops one cycle after en
    always_ff @(posedge mdll_clk or negedge rst_n) begin
        if (!rst_n) begin
            run <= 1'b0;
        end else begin
            run <= en;
        end
    end

endmodule

`default_nettype wire

//--- rtl/hr_16t4_mux.sv
`timescale 1ns/1ns
`default_nettype none

module hr_16t4_mux (
    input  wire logic          mdll_clk,
    input  wire logic          rst_n,
    input  wire tx_pkg::word_t din,        // Parallel word, valid at word_load
    input  wire logic          word_load,  // Capture strobe
    input  wire logic          nib_load,   // Nibble strobe from divider
    output tx_pkg::nibble_t    nib         // Quarter-rate group to the 4:1 mux
);

    import tx_pkg::*;

    word_t      reorder;   // din in tree layout
    word_t      word_q;    // Captured word
    logic [1:0] seq;       // Nibble index within the word
    logic [1:0] grp;       // Group for this index
    logic       nib_stb;   // nib_load one cycle late
    nibble_t    grp_bits;  // Selected group

    // Tree layout, sequence s bit b goes to slot 4*b + bitrev(s)
    // So group 0 holds din[15:12], group 2 din[11:8] and so on
    always_comb begin
        reorder = '0;
        for (int s = 0; s < 4; s++) begin
            for (int b = 0; b < 4; b++) begin
                reorder[4*b + 2*(s%2) + s/2] = din[15 - 4*s - b];
            end
        end
    end

    // Index 0,1,2,3 maps to group 0,2,1,3
    assign grp = {seq[0], seq[1]};

    // Group n holds slots n, n+4, n+8, n+12
    always_comb begin
        for (int j = 0; j < 4; j++) begin
            grp_bits[j] = word_q[4*j + grp];
        end
    end

    always_ff @(posedge mdll_clk or negedge rst_n) begin
        if (!rst_n) begin
            word_q  <= '0;
            seq     <= '0;
            nib_stb <= 1'b0;
            nib     <= '0;
        end else begin
            nib_stb <= nib_load;  // Lets word_q settle first
            if (word_load) begin
                word_q <= reorder;
                seq    <= '0;  // New word starts at group 0
            end else if (nib_stb) begin
                seq <= seq + 2'd1;
            end
            // First group one cycle after capture
            if (nib_stb) begin
                nib <= grp_bits;
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/qr_4t1_mux.sv
`timescale 1ns/1ns
`default_nettype none

module qr_4t1_mux (
    input  wire logic            mdll_clk,
    input  wire logic            rst_n,
    input  wire tx_pkg::nibble_t nib,       // Group from the 16:4 stage
    input  wire logic            nib_load,  // Phase alignment strobe
    output logic                 bit_out    // Serial bit stream
);

    import tx_pkg::*;

    qphase_e phase;  // Current quarter phase
    nibble_t hold;   // Nibble being sent

    // nib_load marks the last slot of a nibble period
    // so the phase walks ph_ib then ph_q while the next group settles
    always_ff @(posedge mdll_clk or negedge rst_n) begin
        if (!rst_n) begin
            phase <= ph_q;
        end else if (nib_load) begin
            phase <= ph_ib;  // Realign to the divider
        end else begin
            phase <= qphase_e'(phase + 2'd1);  // q, i, qb, ib
        end
    end

    // Bit 0 goes straight from nib, the rest from hold
    always_ff @(posedge mdll_clk or negedge rst_n) begin
        if (!rst_n) begin
            hold    <= '0;
            bit_out <= 1'b0;
        end else if (phase == ph_q) begin
            hold    <= nib;     // Grab new group
            bit_out <= nib[0];  // One cycle from nibble to bit
        end else begin
            bit_out <= hold[phase];
        end
    end

endmodule

`default_nettype wire

//--- rtl/bit_delay_line.sv
`timescale 1ns/1ns
`default_nettype none

module bit_delay_line #(
    parameter int DELAY_W = tx_pkg::DELAY_W_DEF  // Code width, 1 to 6
) (
    input  wire logic               mdll_clk,
    input  wire logic               rst_n,
    input  wire logic               bit_in,      // Serial stream from 4:1 mux
    input  wire logic               run,         // Output enable level
    input  wire logic [DELAY_W-1:0] phase_code,  // Whole-bit delay request
    input  wire logic               ctl_valid,   // Code update strobe
    output logic                    dout_p,
    output logic                    dout_n
);

    // Taps 0 to 2^DELAY_W-1, tap 0 is the undelayed input
    localparam int NTAP = 2**DELAY_W;

    logic [DELAY_W-1:0] code;   // Active delay code
    logic [NTAP-1:1]    line;   // line[k] is bit_in from k cycles ago
    logic [NTAP-1:0]    taps;   // All delay taps
    logic               bit_q;  // Retimed output bit

    assign taps = {line, bit_in};

    // Takes effect on the very next bit
    always_ff @(posedge mdll_clk or negedge rst_n) begin
        if (!rst_n) begin
            code <= '0;
        end else if (ctl_valid) begin
            code <= phase_code;
        end
    end

    always_ff @(posedge mdll_clk or negedge rst_n) begin
        if (!rst_n) begin
            line <= '0;
        end else begin
            line <= taps[NTAP-2:0];  // Shift by one bit
        end
    end

    // Single output register, total latency 1 + code
    always_ff @(posedge mdll_clk or negedge rst_n) begin
        if (!rst_n) begin
            bit_q <= 1'b0;
        end else begin
            bit_q <= taps[code];
        end
    end

    // Both legs low when idle
    // run and bit_q are both flops, so the pair stays clean
    assign dout_p = run & bit_q;
    assign dout_n = run & ~bit_q;  // Complement of the same stream

endmodule

`default_nettype wire

//--- rtl/tx_top.sv
`timescale 1ns/1ns
`default_nettype none

module tx_top #(
    parameter int DELAY_W = tx_pkg::DELAY_W_DEF  // Delay code width
) (
    input  wire logic               mdll_clk,    // Bit-rate clock
    input  wire logic               rst_n,
    input  wire logic               en,          // Transmit enable
    input  wire tx_pkg::word_t      din,         // Parallel word from source
    input  wire logic [DELAY_W-1:0] phase_code,  // Whole-bit output delay
    input  wire logic               ctl_valid,   // Loads phase_code
    output logic                    word_req,    // Source updates din here
    output logic                    dout_p,      // Serial data out
    output logic                    dout_n       // Inverted serial data out
);

    import tx_pkg::*;

    logic    nib_load;  // Quarter-rate strobe
    logic    run;       // Datapath active
    nibble_t nib;       // 16:4 to 4:1 group
    logic    bit_s;     // Serial bit before delay

    // Word and nibble timing
    input_divider i_input_divider (
        .mdll_clk  (mdll_clk),
        .rst_n     (rst_n),
        .en        (en),
        .word_load (word_req),  // Capture edge doubles as request
        .nib_load  (nib_load),
        .run       (run)
    );

    // Word capture, reorder and nibble split
    hr_16t4_mux i_hr_16t4_mux (
        .mdll_clk  (mdll_clk),
        .rst_n     (rst_n),
        .din       (din),
        .word_load (word_req),
        .nib_load  (nib_load),
        .nib       (nib)
    );

    // Nibble to bit serializer
    qr_4t1_mux i_qr_4t1_mux (
        .mdll_clk (mdll_clk),
        .rst_n    (rst_n),
        .nib      (nib),
        .nib_load (nib_load),
        .bit_out  (bit_s)
    );

    // Programmable delay and output pair
    bit_delay_line #(
        .DELAY_W (DELAY_W)
    ) i_bit_delay_line (
        .mdll_clk   (mdll_clk),
        .rst_n      (rst_n),
        .bit_in     (bit_s),
        .run        (run),
        .phase_code (phase_code),
        .ctl_valid  (ctl_valid),
        .dout_p     (dout_p),
        .dout_n     (dout_n)
    );

endmodule

`default_nettype wire

//--- testbench/tx_top_sva.sv
`timescale 1ns/1ns

module tx_top_sva (
    input logic mdll_clk,
    input logic rst_n,
    input logic en,
    input logic word_req,
    input logic dout_p,
    input logic dout_n
);

    logic [4:0] gap;       // Saturating count of edges since the last word_req
    logic       en_broke;  // en seen low since the last word_req

    always_ff @(posedge mdll_clk or negedge rst_n) begin
        if (!rst_n) begin
            gap      <= 5'd31;
            en_broke <= 1'b1;
        end else begin
            if (word_req) begin
                gap <= 5'd0;
            end else if (gap != 5'd31) begin
                gap <= gap + 5'd1;
            end
            if (word_req) begin
                en_broke <= 1'b0;
            end else if (!en) begin
                en_broke <= 1'b1;
            end
        end
    end

    // At least 15 quiet cycles after each request
    a_req_gap: assert property (@(posedge mdll_clk) disable iff (!rst_n)
        word_req |-> gap >= 5'd15)
        else $error("word_req less than 16 cycles after the previous one");

    // Exactly 15 while en stays high
    a_req_period: assert property (@(posedge mdll_clk) disable iff (!rst_n)
        (gap == 5'd15 && !en_broke && en) |-> word_req)
        else $error("word_req missing 16 cycles after the previous one");

    // Datapath gate follows en one cycle late
    a_diff_pair: assert property (@(posedge mdll_clk) disable iff (!rst_n)
        $past(en) |-> (dout_n == !dout_p))
        else $error("dout_n is not the inverse of dout_p");

    a_idle_pair: assert property (@(posedge mdll_clk) disable iff (!rst_n)
        !$past(en) |-> (!dout_p && !dout_n))
        else $error("output pair not parked low while idle");

endmodule

bind tx_top tx_top_sva i_tx_top_sva (
    .mdll_clk (mdll_clk),
    .rst_n    (rst_n),
    .en       (en),
    .word_req (word_req),
    .dout_p   (dout_p),
    .dout_n   (dout_n)
);

//--- testbench/tb_tx_top.sv
`timescale 1ns/1ns

module tb_tx_top;

    import tx_pkg::*;

    localparam int DELAY_W     = DELAY_W_DEF;
    localparam int IDLE_CYC    = 40;
    localparam int N_RAND      = 40;
    localparam int N_CODES     = 5;
    localparam int N_WORDS     = 3 + N_RAND + 4 * N_CODES + 5;  // All words sent
    localparam int N_STREAMS   = 2 + N_CODES + 2;              // Times en is raised
    // Ramp, latency, drain and control cycles per stream on top of 16 per word
    localparam int TIMEOUT_CYC = IDLE_CYC + 16 * N_WORDS
                                 + N_STREAMS * (48 + 2**DELAY_W) + 200;

    logic               mdll_clk;
    logic               rst_n;
    logic               en;
    word_t              din = '0;     // Owned by the monitor block
    logic [DELAY_W-1:0] phase_code;
    logic               ctl_valid;
    logic               word_req;
    logic               dout_p;
    logic               dout_n;

    int          cyc = 0;           // Edge counter, also drives the timeout
    int          bits_checked = 0;  // Serial bits compared so far
    int          cur_delay = 0;     // Code the DUT should hold
    int          stim_errors = 0;
    int          stim_checks = 0;
    int          mon_errors = 0;
    int          mon_checks = 0;
    int          diff_errors = 0;
    int          diff_checks = 0;
    int          idle_cnt = 0;      // Edges with en low, saturates at 2
    int          test_err0;
    int          test_chk0;
    string       test_name = "reset";
    logic [31:0] lfsr = 32'hab5d_2c1d;
    word_t       src_q[$];          // Words waiting for a word_req
    logic        exp_bit_q[$];      // Expected dout_p bits
    int          exp_due_q[$];      // Edge at which each bit is due

    tx_top #(
        .DELAY_W (DELAY_W)
    ) i_tx_top (
        .mdll_clk   (mdll_clk),
        .rst_n      (rst_n),
        .en         (en),
        .din        (din),
        .phase_code (phase_code),
        .ctl_valid  (ctl_valid),
        .word_req   (word_req),
        .dout_p     (dout_p),
        .dout_n     (dout_n)
    );

    initial begin
        mdll_clk = 1'b0;
        forever #4 mdll_clk = ~mdll_clk;  // 8 ns period
    end

    always @(posedge mdll_clk) begin
        cyc <= cyc + 1;
    end

    // Galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    // Position i of the result is the i-th bit on the line, MSB of the word first
    function automatic logic [15:0] serial_order(input word_t w);
        logic [15:0] s;
        for (int i = 0; i < 16; i++) begin
            s[i] = w[15 - i];
        end
        return s;
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            val  = {val[30:0], lfsr[0]};  // One LFSR step per bit
            lfsr = lfsr_step(lfsr);
        end
    endtask

    task automatic queue_word(input word_t w);
        src_q.push_back(w);
    endtask

    // Code load strobe, only while en is low
    task automatic set_delay(input logic [DELAY_W-1:0] code);
        @(posedge mdll_clk);
        phase_code <= code;
        ctl_valid  <= 1'b1;
        @(posedge mdll_clk);
        ctl_valid  <= 1'b0;
        cur_delay = int'(code);
    endtask

    // Raise en, wait until all queued words are checked, then park
    task automatic run_stream(input int n_words);
        int target;
        target = bits_checked + 16 * n_words;
        @(posedge mdll_clk);
        en <= 1'b1;
        while (bits_checked < target) begin
            @(posedge mdll_clk);
        end
        en <= 1'b0;
        src_q.delete();
        repeat (4) @(posedge mdll_clk);  // Outputs back to idle
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        test_err0 = stim_errors + mon_errors;
        test_chk0 = stim_checks + mon_checks;
    endtask

    task automatic end_test;
        int e;
        int c;
        e = stim_errors + mon_errors - test_err0;
        c = stim_checks + mon_checks - test_chk0;
        if (e == 0) begin
            $display("test %s: ok, %0d checks", test_name, c);
        end else begin
            $display("test %s: %0d errors in %0d checks", test_name, e, c);
        end
    endtask

    // Reference queue, compare and din source in one clocked process
    always @(posedge mdll_clk) begin
        logic [15:0] seq;
        if (rst_n) begin
            if (dout_p === 1'b1 && dout_n === 1'b1) begin
                $display("%s: dout_p and dout_n both high at cycle %0d", test_name, cyc);
                mon_errors++;
            end
            if (idle_cnt >= 2 && (dout_p !== 1'b0 || dout_n !== 1'b0)) begin
                $display("FAIL %s idle pair: expected 00 actual %b%b",
                         test_name, dout_p, dout_n);
                mon_errors++;
            end
            if (!en) begin
                exp_bit_q.delete();  // Stream aborted or finished
                exp_due_q.delete();
                if (idle_cnt < 2) begin
                    idle_cnt++;
                end
            end else begin
                idle_cnt = 0;
                // First bit shows in the cycle after E+3+d
                if (exp_due_q.size() > 0 && exp_due_q[0] == cyc) begin
                    mon_checks++;
                    diff_checks++;
                    if (dout_p !== exp_bit_q[0]) begin
                        $display("FAIL %s at cycle %0d: expected %b actual %b",
                                 test_name, cyc, exp_bit_q[0], dout_p);
                        mon_errors++;
                    end
                    if (dout_n !== ~exp_bit_q[0]) begin
                        $display("FAIL %s dout_n at cycle %0d: expected %b actual %b",
                                 test_name, cyc, ~exp_bit_q[0], dout_n);
                        mon_errors++;
                        diff_errors++;
                    end
                    void'(exp_bit_q.pop_front());
                    void'(exp_due_q.pop_front());
                    bits_checked <= bits_checked + 1;
                end
                if (word_req) begin
                    seq = serial_order(din);  // Word the DUT captures here
                    for (int i = 0; i < 16; i++) begin
                        exp_bit_q.push_back(seq[i]);
                        exp_due_q.push_back(cyc + 4 + cur_delay + i);
                    end
                    if (src_q.size() > 0) begin
                        void'(src_q.pop_front());
                    end
                end
            end
            din <= (src_q.size() > 0) ? src_q[0] : word_t'(0);  // Next word ready early
        end
    end

    initial begin
        while (cyc < TIMEOUT_CYC) begin
            @(posedge mdll_clk);
        end
        $display("timeout: run still going after %0d cycles", cyc);
        $display("** FAIL **");
        $finish;
    end

    initial begin
        logic [31:0] rnd;
        int          n;
        int          base;
        logic        seen;
        rst_n      <= 1'b0;
        en         <= 1'b0;
        phase_code <= '0;
        ctl_valid  <= 1'b0;
        repeat (3) @(posedge mdll_clk);
        rst_n <= 1'b1;

        begin_test("idle");
        repeat (IDLE_CYC) begin
            @(posedge mdll_clk);
            stim_checks++;
            if (word_req !== 1'b0 || dout_p !== 1'b0 || dout_n !== 1'b0) begin
                $display("FAIL idle: expected 000 actual %b%b%b", word_req, dout_p, dout_n);
                stim_errors++;
            end
        end
        end_test();

        begin_test("order");
        queue_word(16'h8000);
        queue_word(16'h0001);
        queue_word(16'hA5C3);
        run_stream(3);
        end_test();

        begin_test("random");
        for (int k = 0; k < N_RAND; k++) begin
            draw_bits(16, rnd);
            queue_word(rnd[15:0]);
        end
        run_stream(N_RAND);
        end_test();

        begin_test("delay");
        for (int k = 0; k < N_CODES; k++) begin
            draw_bits(DELAY_W, rnd);
            set_delay(rnd[DELAY_W-1:0]);
            queue_word(16'h8000);  // Lone one pins the offset
            for (int j = 0; j < 3; j++) begin
                draw_bits(16, rnd);
                queue_word(rnd[15:0]);
            end
            run_stream(4);
        end
        end_test();

        if (diff_errors == 0) begin
            $display("test differential: ok, %0d cycles", diff_checks);
        end else begin
            $display("test differential: %0d errors in %0d cycles", diff_errors, diff_checks);
        end

        begin_test("restart");
        for (int k = 0; k < 3; k++) begin
            draw_bits(16, rnd);
            queue_word(rnd[15:0]);
        end
        base = bits_checked;
        @(posedge mdll_clk);
        en <= 1'b1;
        while (bits_checked < base + 22) begin
            @(posedge mdll_clk);
        end
        en <= 1'b0;  // Six bits into the second word
        src_q.delete();
        repeat (4) @(posedge mdll_clk);
        for (int k = 0; k < 2; k++) begin
            draw_bits(16, rnd);
            queue_word(rnd[15:0]);
        end
        base = bits_checked;
        @(posedge mdll_clk);
        en <= 1'b1;
        n    = 0;
        seen = 1'b0;
        while (!seen && n < 40) begin
            @(posedge mdll_clk);
            n++;
            seen = word_req;
        end
        stim_checks++;
        if (!seen) begin
            $display("restart: no word_req within 40 cycles after en rose");
            stim_errors++;
        end else if (n != 16) begin
            $display("FAIL restart: expected word_req in cycle 16 actual cycle %0d", n);
            stim_errors++;
        end
        while (bits_checked < base + 32) begin
            @(posedge mdll_clk);
        end
        en <= 1'b0;
        src_q.delete();
        repeat (4) @(posedge mdll_clk);
        end_test();

        $display("checks %0d, errors %0d", stim_checks + mon_checks, stim_errors + mon_errors);
        if (stim_errors + mon_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- build.f
rtl/tx_pkg.sv
rtl/input_divider.sv
rtl/hr_16t4_mux.sv
rtl/qr_4t1_mux.sv
rtl/bit_delay_line.sv
rtl/tx_top.sv
testbench/tx_top_sva.sv
testbench/tb_tx_top.sv

//--- Makefile
# Verilator flow for the 16:1 serializer

VERILATOR ?= verilator
TOP       ?= tb_tx_top
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= ** PASS **

SRCS := $(wildcard rtl/*.sv) $(wildcard testbench/*.sv)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

# Fails unless the pass line shows up in the output
sim: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
